// ==== source/dma_pkg.sv ====
/*
  Shared constants and state encodings for the sprite/DMC DMA block.
  CPU_DIV must stay a whole number of master clocks per CPU cycle.
  PAGE_BYTES must be a power of two so the page index wraps cleanly.
*/
package dma_pkg;

	// Bus widths
	localparam int ADDR_W = 16;	// CPU address bus
	localparam int DATA_W = 8;	// CPU data bus

	// Master clocks per CPU cycle (NTSC ratio)
	localparam int CPU_DIV = 12;
	localparam int DIV_W   = $clog2(CPU_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CPU_DIV - 1);	// Count that fires cpu_ce

	// Register map
	localparam logic [ADDR_W-1:0] SPRITE_DMA_REG = 16'h4014;	// Write page here to start
	localparam logic [ADDR_W-1:0] OAM_DATA_ADDR  = 16'h2004;	// Every sprite write lands here

	// One sprite transfer is a full CPU page
	localparam int PAGE_BYTES  = 256;
	localparam int PAGE_IDX_W  = $clog2(PAGE_BYTES);
	localparam logic [PAGE_IDX_W-1:0] IDX_LAST = PAGE_IDX_W'(PAGE_BYTES - 1);

	// Sprite DMA state
	// Bit 0 set while the CPU is held, bit 1 set while bytes move
	typedef enum logic [1:0] {
		SPR_IDLE  = 2'b00,	// No transfer
		SPR_ALIGN = 2'b01,	// CPU stalled, waiting for a get cycle
		SPR_RUN   = 2'b11	// Read on get, write on put
	} spr_state_t;

	// DMC fetch state
	typedef enum logic {
		DMC_IDLE  = 1'b0,	// Nothing pending
		DMC_FETCH = 1'b1	// Fetch on the coming get cycle
	} dmc_state_t;

endpackage

// ==== source/cycle_timer.sv ====
/*
  CPU clock enable and get/put parity.
  First cpu_ce arrives CPU_DIV clocks after reset is released, and is a put cycle.
  No PAL tick insertion. The divide ratio is fixed.
*/
`timescale 1ns/100ps

module cycle_timer (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,	// One clock high every CPU_DIV clocks
	output logic put_cycle,	// 1 during put cycles, 0 during get cycles
	output logic get_ce,	// cpu_ce of a get cycle
	output logic put_ce	// cpu_ce of a put cycle
);

	logic [dma_pkg::DIV_W-1:0] div_cnt;	// Master clocks into the current CPU cycle

	// Master clock divider
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0;	// Start next CPU cycle
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Strobe on the last master clock of the CPU cycle
	assign cpu_ce = (div_cnt == dma_pkg::DIV_LAST);

	// Get/put parity
	// Flips at the end of every CPU cycle so that reads and writes alternate
	always_ff @(posedge clk) begin
		if (reset) begin
			put_cycle <= 1'b1;	// First cycle after reset is a put
		end else if (cpu_ce) begin
			put_cycle <= ~put_cycle;
		end
	end

	// Split the CPU strobe by parity
	assign get_ce = cpu_ce & ~put_cycle;
	assign put_ce = cpu_ce & put_cycle;

endmodule

// ==== source/dma_sequencer.sv ====
/*
  Sprite and DMC DMA state machines with the CPU stall request.
  All state moves on cpu_ce only. DMC has priority and bumps a running
  sprite transfer back to alignment. cpu_rnw must be valid on every cpu_ce.
*/
`timescale 1ns/100ps

module dma_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic get_ce,
	input  logic put_ce,
	input  logic [dma_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [dma_pkg::DATA_W-1:0] cpu_dout,
	input  logic cpu_rnw,	// 1 = CPU read cycle
	input  logic dmc_request,	// Level from the audio unit
	output dma_pkg::spr_state_t spr_state,
	output dma_pkg::dmc_state_t dmc_state,
	output logic [dma_pkg::ADDR_W-1:0] sprite_addr,	// Page and index of next sprite read
	output logic pause_cpu
);

	logic [dma_pkg::DATA_W-1:0]     spr_page;	// Source page from $4014
	logic [dma_pkg::PAGE_IDX_W-1:0] spr_index;	// Byte within the page
	logic spr_write;	// CPU writes the sprite DMA register
	logic dmc_grant;	// Current get cycle belongs to DMC

	// Register decode qualified later by cpu_ce
	assign spr_write = (cpu_addr == dma_pkg::SPRITE_DMA_REG) && !cpu_rnw;

	// Same condition the bus driver uses for dmc_ack on a get cycle
	// A request that already fell leaves the get cycle to sprite DMA
	assign dmc_grant = (dmc_state == dma_pkg::DMC_FETCH) && dmc_request;

	// DMC fetch FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= dma_pkg::DMC_IDLE;
		end else if (cpu_ce) begin
			case (dmc_state)
				dma_pkg::DMC_IDLE: begin
					// Only schedule behind a CPU read since writes cannot be halted
					if (put_ce && dmc_request && cpu_rnw) begin
						dmc_state <= dma_pkg::DMC_FETCH;
					end
				end
				dma_pkg::DMC_FETCH: begin
					if (put_ce) begin
						dmc_state <= dma_pkg::DMC_IDLE;	// Fetch done on the get just past
					end
				end
				default: dmc_state <= dma_pkg::DMC_IDLE;
			endcase
		end
	end

	// Sprite DMA FSM and source address
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= dma_pkg::SPR_IDLE;
			spr_page  <= '0;
			spr_index <= '0;
		end else if (cpu_ce) begin
			case (spr_state)
				dma_pkg::SPR_IDLE: begin
					if (spr_write) begin
						spr_page  <= cpu_dout;	// Page number written by CPU
						spr_index <= '0;
						spr_state <= dma_pkg::SPR_ALIGN;
					end
				end
				dma_pkg::SPR_ALIGN: begin
					// Start on a get cycle once the CPU sits in a read
					if (get_ce && cpu_rnw) begin
						spr_state <= dma_pkg::SPR_RUN;
					end
				end
				dma_pkg::SPR_RUN: begin
					if (put_ce && (dmc_state == dma_pkg::DMC_FETCH)) begin
						spr_state <= dma_pkg::SPR_ALIGN;	// DMC took a slot so realign
					end else if (get_ce && !dmc_grant) begin
						spr_index <= spr_index + 1'b1;	// Byte read this cycle
						if (spr_index == dma_pkg::IDX_LAST) begin
							spr_state <= dma_pkg::SPR_IDLE;	// Last byte read
						end
					end
				end
				default: spr_state <= dma_pkg::SPR_IDLE;
			endcase
		end
	end

	assign sprite_addr = {spr_page, spr_index};

	// Stall the CPU while any DMA owns or is about to own the bus
	// dmc_request alone is enough so the CPU stops before the fetch is scheduled
	assign pause_cpu = (spr_state != dma_pkg::SPR_IDLE) ||
		dmc_request ||
		(dmc_state == dma_pkg::DMC_FETCH);

endmodule

// ==== source/dma_bus_driver.sv ====
/*
  Bus side of the DMA block.
  Reads happen on get cycles, writes on put cycles. The sprite byte is held
  from its read to the following write. dmc_ack is combinational.
*/
`timescale 1ns/100ps

module dma_bus_driver (
	input  logic clk,
	input  logic reset,
	input  logic get_ce,
	input  logic put_cycle,	// 0 = get (read) cycle
	input  dma_pkg::spr_state_t spr_state,
	input  dma_pkg::dmc_state_t dmc_state,
	input  logic dmc_request,
	input  logic [dma_pkg::ADDR_W-1:0] dmc_addr,
	input  logic [dma_pkg::ADDR_W-1:0] sprite_addr,
	input  logic [dma_pkg::DATA_W-1:0] ram_data,	// Byte on the data bus
	output logic [dma_pkg::ADDR_W-1:0] bus_addr,
	output logic [dma_pkg::DATA_W-1:0] bus_wdata,
	output logic bus_read,	// 1 = read, 0 = write
	output logic bus_enable,	// DMA drives the bus this cycle
	output logic dmc_ack
);

	logic [dma_pkg::DATA_W-1:0] spr_byte;	// Sprite byte between read and write
	logic spr_run;

	assign spr_run = (spr_state == dma_pkg::SPR_RUN);

	// DMC grant on a get cycle
	// The request can fall before the fetch and then the slot is not claimed
	assign dmc_ack = (dmc_state == dma_pkg::DMC_FETCH) && !put_cycle && dmc_request;

	// Direction follows parity only
	assign bus_read = !put_cycle;

	assign bus_enable = dmc_ack || spr_run;

	// Address select with DMC first
	always_comb begin
		if (dmc_ack) begin
			bus_addr = dmc_addr;
		end else if (!put_cycle) begin
			bus_addr = sprite_addr;	// Sprite source read
		end else begin
			bus_addr = dma_pkg::OAM_DATA_ADDR;	// Sprite write to OAM
		end
	end

	// Capture the sprite byte at the end of its read cycle
	// A DMC fetch on this get leaves the old byte in place
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_byte <= '0;
		end else if (get_ce && spr_run && !dmc_ack) begin
			spr_byte <= ram_data;
		end
	end

	assign bus_wdata = spr_byte;

endmodule

// ==== source/dma_top.sv ====
/*
  Sprite and DMC DMA controller with its CPU clock enable.
  Inputs are sampled on cpu_ce. The bus outputs are valid only while
  bus_enable is high, otherwise the CPU owns the bus.
*/
`timescale 1ns/100ps

module dma_top (
	input  logic clk,
	input  logic reset,
	// CPU cycle in progress
	input  logic [dma_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [dma_pkg::DATA_W-1:0] cpu_dout,
	input  logic cpu_rnw,
	// DMC side
	input  logic dmc_request,
	input  logic [dma_pkg::ADDR_W-1:0] dmc_addr,
	// Data bus
	input  logic [dma_pkg::DATA_W-1:0] ram_data,
	output logic cpu_ce,
	output logic [dma_pkg::ADDR_W-1:0] bus_addr,
	output logic bus_enable,
	output logic bus_read,
	output logic [dma_pkg::DATA_W-1:0] bus_wdata,
	output logic dmc_ack,
	output logic pause_cpu
);

	logic put_cycle;
	logic get_ce;
	logic put_ce;
	dma_pkg::spr_state_t spr_state;
	dma_pkg::dmc_state_t dmc_state;
	logic [dma_pkg::ADDR_W-1:0] sprite_addr;

	// CPU cycle pacing
	cycle_timer i_timer (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.put_cycle (put_cycle),
		.get_ce    (get_ce),
		.put_ce    (put_ce)
	);

	// Request side with both FSMs
	dma_sequencer i_seq (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.get_ce      (get_ce),
		.put_ce      (put_ce),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.cpu_rnw     (cpu_rnw),
		.dmc_request (dmc_request),
		.spr_state   (spr_state),
		.dmc_state   (dmc_state),
		.sprite_addr (sprite_addr),
		.pause_cpu   (pause_cpu)
	);

	// Bus side and sprite byte latch
	dma_bus_driver i_bus (
		.clk         (clk),
		.reset       (reset),
		.get_ce      (get_ce),
		.put_cycle   (put_cycle),
		.spr_state   (spr_state),
		.dmc_state   (dmc_state),
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.sprite_addr (sprite_addr),
		.ram_data    (ram_data),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_read    (bus_read),
		.bus_enable  (bus_enable),
		.dmc_ack     (dmc_ack)
	);

endmodule

// ==== verification/dma_properties.sv ====
/*
  Bus checks for dma_top, attached with bind.
  Write data is compared with the memory rule low byte XOR page byte,
  so it only holds for a memory that answers that way.
*/
`timescale 1ns/100ps

module dma_properties (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic [dma_pkg::ADDR_W-1:0] cpu_addr,
	input logic cpu_rnw,
	input logic dmc_request,
	input logic [dma_pkg::ADDR_W-1:0] dmc_addr,
	input logic [dma_pkg::ADDR_W-1:0] bus_addr,
	input logic bus_enable,
	input logic bus_read,
	input logic [dma_pkg::DATA_W-1:0] bus_wdata,
	input logic dmc_ack,
	input logic pause_cpu
);

	int fail_count = 0;	// Failed assertions, read by the testbench
	int since_ce;	// Master clocks since the last cpu_ce
	logic armed;	// Some DMA trigger has been seen
	logic seen_ce;
	logic last_read;	// bus_read of the previous CPU cycle
	logic have_read;	// A sprite read happened in this transfer
	logic [dma_pkg::ADDR_W-1:0] last_addr;	// Address of that read
	logic spr_write;
	logic spr_read;
	logic oam_write;

	assign spr_write = cpu_ce && (cpu_addr == dma_pkg::SPRITE_DMA_REG) && !cpu_rnw;
	assign spr_read  = cpu_ce && bus_enable && bus_read && !dmc_ack;	// DMC reads excluded
	assign oam_write = cpu_ce && bus_enable && !bus_read;

	always_ff @(posedge clk) begin
		if (reset) begin
			since_ce  <= 0;
			armed     <= 1'b0;
			seen_ce   <= 1'b0;
			last_read <= 1'b0;
			have_read <= 1'b0;
			last_addr <= '0;
		end else begin
			since_ce <= cpu_ce ? 0 : since_ce + 1;
			if (spr_write || dmc_request) begin
				armed <= 1'b1;
			end
			if (cpu_ce) begin
				seen_ce   <= 1'b1;
				last_read <= bus_read;
			end
			if (spr_write) begin
				have_read <= 1'b0;	// New transfer, old byte no longer counts
			end else if (spr_read) begin
				have_read <= 1'b1;
				last_addr <= bus_addr;
			end
		end
	end

	// One cpu_ce every CPU_DIV clocks
	a_ce_period: assert property (@(posedge clk) disable iff (reset)
		cpu_ce == (since_ce == dma_pkg::CPU_DIV - 1))
		else begin
			$error("cpu_ce out of step, %0d clocks since the last one", since_ce);
			fail_count++;
		end

	a_read_alternates: assert property (@(posedge clk) disable iff (reset)
		cpu_ce && pause_cpu && seen_ce |-> bus_read != last_read)
		else begin
			$error("bus_read did not alternate during DMA");
			fail_count++;
		end

	// Quiet outputs until the first trigger
	a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
		!(armed || dmc_request) |-> !pause_cpu && !bus_enable && !dmc_ack)
		else begin
			$error("DMA outputs active before any trigger");
			fail_count++;
		end

	a_oam_addr: assert property (@(posedge clk) disable iff (reset)
		oam_write |-> bus_addr == dma_pkg::OAM_DATA_ADDR)
		else begin
			$error("sprite write to %h instead of OAM data", bus_addr);
			fail_count++;
		end

	a_oam_data: assert property (@(posedge clk) disable iff (reset)
		oam_write && have_read |-> bus_wdata == (last_addr[7:0] ^ last_addr[15:8]))
		else begin
			$error("sprite write data %h does not match read of %h", bus_wdata, last_addr);
			fail_count++;
		end

	a_dmc_bus: assert property (@(posedge clk) disable iff (reset)
		cpu_ce && dmc_ack |-> bus_read && bus_addr == dmc_addr)
		else begin
			$error("DMC fetch at %h instead of %h", bus_addr, dmc_addr);
			fail_count++;
		end

endmodule

bind dma_top dma_properties i_props (
	.clk         (clk),
	.reset       (reset),
	.cpu_ce      (cpu_ce),
	.cpu_addr    (cpu_addr),
	.cpu_rnw     (cpu_rnw),
	.dmc_request (dmc_request),
	.dmc_addr    (dmc_addr),
	.bus_addr    (bus_addr),
	.bus_enable  (bus_enable),
	.bus_read    (bus_read),
	.bus_wdata   (bus_wdata),
	.dmc_ack     (dmc_ack),
	.pause_cpu   (pause_cpu)
);

// ==== verification/dma_tb.sv ====
/*
  Testbench for dma_top: idle pacing, sprite DMA, DMC preemption, DMC alone.
  Memory answers low address byte XOR high address byte on read cycles.
  Bus protocol checks live in the bound property module.
*/
`timescale 1ns/100ps

module dma_tb;

	localparam int CLK_PERIOD  = 100;	// ns
	localparam int PAGE        = 256;	// Bytes per sprite transfer
	localparam int XFER_CYCLES = 2 + 2 * PAGE;	// Alignment plus get/put pairs
	localparam int XFER_CLOCKS = XFER_CYCLES * dma_pkg::CPU_DIV;
	localparam logic [dma_pkg::ADDR_W-1:0] SPRITE_REG = 16'h4014;
	localparam logic [dma_pkg::ADDR_W-1:0] IDLE_ADDR  = 16'h8000;	// CPU parked on a ROM read

	logic clk;
	logic reset;
	logic [dma_pkg::ADDR_W-1:0] cpu_addr;
	logic [dma_pkg::DATA_W-1:0] cpu_dout;
	logic cpu_rnw;
	logic dmc_request;
	logic [dma_pkg::ADDR_W-1:0] dmc_addr;
	logic [dma_pkg::DATA_W-1:0] ram_data = '0;
	logic cpu_ce;
	logic [dma_pkg::ADDR_W-1:0] bus_addr;
	logic bus_enable;
	logic bus_read;
	logic [dma_pkg::DATA_W-1:0] bus_wdata;
	logic dmc_ack;
	logic pause_cpu;

	string cur_test;
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int read_count;	// Sprite reads seen in this test
	int ack_count;
	logic [7:0] next_idx;	// Expected index of the next sprite read
	logic [dma_pkg::DATA_W-1:0] page;

	dma_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.cpu_rnw     (cpu_rnw),
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.ram_data    (ram_data),
		.cpu_ce      (cpu_ce),
		.bus_addr    (bus_addr),
		.bus_enable  (bus_enable),
		.bus_read    (bus_read),
		.bus_wdata   (bus_wdata),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Memory model answers on read cycles only
	always @(posedge clk) begin
		ram_data <= bus_read ? (bus_addr[7:0] ^ bus_addr[15:8]) : 8'h00;
	end

	task automatic show_mismatch(input string test, input longint exp, input longint act);
		$display("Error %s: expected %0h, actual %0h", test, exp, act);
		errors++;
		test_errors++;
	endtask

	task automatic note_problem(input string msg);
		$display("%s: %s", cur_test, msg);
		errors++;
		test_errors++;
	endtask

	// Bus monitor sampled on the last clock of each CPU cycle
	always @(negedge clk) begin
		if (!reset && cpu_ce) begin
			if (bus_enable && bus_read && !dmc_ack) begin
				assert (bus_addr == {page, next_idx})
				else show_mismatch(cur_test, {page, next_idx}, bus_addr);
				read_count++;
				next_idx++;
			end
			if (dmc_ack) begin
				ack_count++;
				assert (bus_read && bus_addr == dmc_addr)
				else show_mismatch(cur_test, dmc_addr, bus_addr);
			end
		end
		if (!reset && dmc_request) begin
			assert (pause_cpu) else show_mismatch(cur_test, 1, pause_cpu);	// Stall while requested
		end
	end

	// Returns on the rising edge that carries cpu_ce
	task automatic next_cpu_cycle();
		@(negedge clk);
		while (!cpu_ce) @(negedge clk);
		@(posedge clk);
	endtask

	task automatic wait_cpu_cycles(input int n);
		repeat (n) next_cpu_cycle();
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
		read_count  = 0;
		ack_count   = 0;
		next_idx    = '0;
	endtask

	task automatic finish_test();
		tests_run++;
		$display("%s: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failing", test_errors);
	endtask

	// CPU write of the page number to the sprite DMA register
	task automatic write_sprite_reg(input logic [7:0] pg);
		next_cpu_cycle();
		cpu_addr <= SPRITE_REG;
		cpu_rnw  <= 1'b0;
		cpu_dout <= pg;
		next_cpu_cycle();	// Write taken on this edge
		cpu_addr <= IDLE_ADDR;
		cpu_rnw  <= 1'b1;
		@(negedge clk);
		assert (pause_cpu) else show_mismatch(cur_test, 1, pause_cpu);
	endtask

	task automatic await_pause_low(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (pause_cpu && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (pause_cpu) begin
			note_problem($sformatf("pause_cpu still high after %0d clocks", limit));
		end
	endtask

	// Wait for the grant and release the request on that cycle's edge
	task automatic await_dmc_ack(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!(cpu_ce && dmc_ack) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!(cpu_ce && dmc_ack)) begin
			note_problem($sformatf("no DMC acknowledge within %0d clocks", limit));
		end
		@(posedge clk);
		dmc_request <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h284c));
		reset       = 1'b1;
		cpu_addr    = IDLE_ADDR;
		cpu_dout    = '0;
		cpu_rnw     = 1'b1;
		dmc_request = 1'b0;
		dmc_addr    = '0;
		page        = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		start_test("pacing_reset");	// Idle bus with pacing and quiet outputs
		wait_cpu_cycles(20);
		@(negedge clk);
		assert (!pause_cpu && !bus_enable) else show_mismatch(cur_test, 0, {pause_cpu, bus_enable});
		finish_test();

		start_test("sprite_transfer");
		page = 8'($urandom);
		write_sprite_reg(page);
		await_pause_low(XFER_CLOCKS);
		assert (read_count == PAGE) else show_mismatch(cur_test, PAGE, read_count);
		finish_test();

		start_test("dmc_preempt");
		page = 8'($urandom);
		write_sprite_reg(page);
		wait_cpu_cycles($urandom_range(400, 10));	// Somewhere inside the transfer
		dmc_addr    <= 16'hC000 | 16'($urandom_range(16'h3FFF, 0));
		dmc_request <= 1'b1;
		await_dmc_ack(16 * dma_pkg::CPU_DIV);
		await_pause_low(XFER_CLOCKS);
		assert (read_count == PAGE) else show_mismatch(cur_test, PAGE, read_count);
		assert (ack_count == 1) else show_mismatch(cur_test, 1, ack_count);
		finish_test();

		start_test("dmc_alone");
		wait_cpu_cycles(4);
		dmc_addr    <= 16'hC000 | 16'($urandom_range(16'h3FFF, 0));
		dmc_request <= 1'b1;
		@(negedge clk);
		assert (pause_cpu) else show_mismatch(cur_test, 1, pause_cpu);
		await_dmc_ack(16 * dma_pkg::CPU_DIV);
		await_pause_low(16 * dma_pkg::CPU_DIV);
		wait_cpu_cycles(4);
		assert (ack_count == 1) else show_mismatch(cur_test, 1, ack_count);
		assert (read_count == 0) else show_mismatch(cur_test, 0, read_count);
		finish_test();

		$display("%0d tests, %0d check errors, %0d assertion failures",
			tests_run, errors, i_dut.i_props.fail_count);
		if (errors == 0 && i_dut.i_props.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog allows three sprite transfers of time
	initial begin
		#(3 * XFER_CLOCKS * CLK_PERIOD);
		$display("Watchdog: run took longer than three sprite transfers");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/dma_pkg.sv
source/cycle_timer.sv
source/dma_sequencer.sv
source/dma_bus_driver.sv
source/dma_top.sv
verification/dma_properties.sv
verification/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the DMA testbench with Verilator and run it
# Exit status is 0 only when the pass message shows up in the output
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dma_tb -f vlog.f

# Let the run reach its own summary instead of stopping at the first $error
output=$(./obj_dir/Vdma_tb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
